// File: source/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and instruction word
`define CPU_DATA_W 32

// Word addresses for the instruction memory and the boot ROM
`define CPU_IM_ADDR_W 10

// Word addresses for the data memory
`define CPU_DM_ADDR_W 12

`define CPU_REG_ADDR_W 5

// Progress counters
`define CPU_CYCLE_W 64
`define CPU_ICNT_W 32

`endif

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  `include "cpu_settings.svh"

  typedef enum logic [5:0] {
    OP_ALU  = 6'h00,
    OP_ADDI = 6'h08,
    OP_ORI  = 6'h0c,
    OP_LWI  = 6'h18,
    OP_SWI  = 6'h19,
    OP_HALT = 6'h3f
  } opcode_e;

  typedef enum logic [4:0] {
    ADD = 5'd0,
    SUB = 5'd1,
    AND = 5'd2,
    OR  = 5'd3,
    XOR = 5'd4
  } alu_func_e;

  // One instruction word, read as register form or immediate form
  typedef union packed {
    struct packed {
      logic [5:0]                 opcode;
      logic [`CPU_REG_ADDR_W-1:0] rd;
      logic [`CPU_REG_ADDR_W-1:0] ra;
      logic [`CPU_REG_ADDR_W-1:0] rb;
      logic [5:0]                 unused;
      logic [4:0]                 func;
    } r;
    struct packed {
      logic [5:0]                 opcode;
      logic [`CPU_REG_ADDR_W-1:0] rd;
      logic [`CPU_REG_ADDR_W-1:0] ra;
      logic                       rsvd;
      logic [14:0]                imm;
    } i;
  } instr_u;

  typedef struct packed {
    logic                  last;
    logic [`CPU_DATA_W-1:0] instr;
  } rom_word_t;

  typedef struct packed {
    opcode_e                    opcode;
    alu_func_e                  func;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [`CPU_REG_ADDR_W-1:0] ra;
    logic [`CPU_REG_ADDR_W-1:0] rb;
    logic [`CPU_DATA_W-1:0]     imm;
    logic                       use_imm;
    logic                       is_load;
    logic                       is_store;
    logic                       writes_reg;
    logic                       is_halt;
  } decoded_t;

  // Instruction addresses are zero-extended into the wider address field
  typedef struct packed {
    logic                      en;
    logic                      write;
    logic [`CPU_DM_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0]    wdata;
  } mem_req_t;

  typedef mem_req_t im_req_t;
  typedef mem_req_t dm_req_t;

  typedef struct packed {
    logic latch_ir;
    logic reg_read;
    logic execute;
    logic mem_access;
    logic write_back;
  } ctrl_step_t;

endpackage

`default_nettype wire

// File: source/cpu_controller.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_controller import cpu_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire decoded_t   dec,
  input  wire logic       boot_last,
  output ctrl_step_t      step,
  output logic            boot_phase,
  output logic            pc_inc,
  output logic            pc_clear,
  output logic            retire,
  output logic            halted
);

  typedef enum logic [2:0] {
    BOOT_READ,
    BOOT_WRITE,
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALTED
  } state_e;

  state_e state;
  state_e state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BOOT_READ;
    end else begin
      state <= state_next;
    end
  end

  // ******************************
  // Next state and step strobes
  // ******************************
  always_comb begin
    state_next = state;
    step       = '0;
    pc_inc     = 1'b0;
    pc_clear   = 1'b0;
    retire     = 1'b0;
    case (state)
      BOOT_READ: begin
        state_next = BOOT_WRITE;
      end
      BOOT_WRITE: begin
        // The last ROM word ends the copy and restarts the PC at zero
        if (boot_last) begin
          pc_clear   = 1'b1;
          state_next = FETCH;
        end else begin
          pc_inc     = 1'b1;
          state_next = BOOT_READ;
        end
      end
      FETCH: begin
        state_next = DECODE;
      end
      DECODE: begin
        step.latch_ir = 1'b1;
        step.reg_read = 1'b1;
        if (dec.is_halt) begin
          retire     = 1'b1;
          state_next = HALTED;
        end else begin
          state_next = EXECUTE;
        end
      end
      EXECUTE: begin
        step.execute = 1'b1;
        if (dec.is_load || dec.is_store) begin
          state_next = MEMORY;
        end else begin
          state_next = WRITEBACK;
        end
      end
      MEMORY: begin
        step.mem_access = 1'b1;
        state_next      = WRITEBACK;
      end
      WRITEBACK: begin
        step.write_back = 1'b1;
        pc_inc          = 1'b1;
        retire          = 1'b1;
        state_next      = FETCH;
      end
      default: begin
        state_next = HALTED;
      end
    endcase
  end

  assign boot_phase = (state == BOOT_READ) || (state == BOOT_WRITE);
  assign halted     = (state == HALTED);

endmodule

`default_nettype wire

// File: source/pc_counter.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module pc_counter (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     pc_inc,
  input  wire logic                     pc_clear,
  input  wire logic                     count_cycles,
  input  wire logic                     retire,
  output logic [`CPU_IM_ADDR_W-1:0]     pc,
  output logic [`CPU_CYCLE_W-1:0]       cycle_cnt,
  output logic [`CPU_ICNT_W-1:0]        instr_cnt
);

  // Remembers the last counted cycle so the one where halted rises is included
  logic count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= '0;
      cycle_cnt <= '0;
      instr_cnt <= '0;
      count_q   <= 1'b0;
    end else begin
      count_q <= count_cycles;
      if (pc_clear) begin
        pc <= '0;
      end else if (pc_inc) begin
        pc <= pc + 1'b1;
      end
      if (count_cycles || count_q) begin
        cycle_cnt <= cycle_cnt + 1'b1;
      end
      if (retire) begin
        instr_cnt <= instr_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module instr_decoder import cpu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire ctrl_step_t             step,
  input  wire logic [`CPU_DATA_W-1:0] im_rdata,
  output decoded_t                    dec
);

  logic [`CPU_DATA_W-1:0] ir_q;
  instr_u                 iw;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir_q <= '0;
    end else if (step.latch_ir) begin
      ir_q <= im_rdata;
    end
  end

  // The fetched word goes straight through while it is being latched,
  // so the register read in DECODE already sees the new fields
  assign iw = step.latch_ir ? im_rdata : ir_q;

  always_comb begin
    dec        = '0;
    dec.opcode = opcode_e'(iw.r.opcode);
    dec.rd     = iw.r.rd;
    dec.ra     = iw.r.ra;
    dec.func   = ADD;
    case (opcode_e'(iw.r.opcode))
      OP_ALU: begin
        dec.rb         = iw.r.rb;
        dec.func       = alu_func_e'(iw.r.func);
        dec.writes_reg = 1'b1;
      end
      OP_ADDI: begin
        dec.imm        = {{(`CPU_DATA_W-15){iw.i.imm[14]}}, iw.i.imm};
        dec.use_imm    = 1'b1;
        dec.writes_reg = 1'b1;
      end
      OP_ORI: begin
        dec.imm        = {{(`CPU_DATA_W-15){1'b0}}, iw.i.imm};
        dec.func       = OR;
        dec.use_imm    = 1'b1;
        dec.writes_reg = 1'b1;
      end
      OP_LWI: begin
        dec.imm        = {{(`CPU_DATA_W-15){iw.i.imm[14]}}, iw.i.imm};
        dec.use_imm    = 1'b1;
        dec.is_load    = 1'b1;
        dec.writes_reg = 1'b1;
      end
      OP_SWI: begin
        dec.imm      = {{(`CPU_DATA_W-15){iw.i.imm[14]}}, iw.i.imm};
        dec.use_imm  = 1'b1;
        dec.is_store = 1'b1;
      end
      OP_HALT: begin
        dec.is_halt = 1'b1;
      end
      default: begin
        // Unknown opcodes retire without any effect
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module regfile import cpu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire ctrl_step_t             step,
  input  wire decoded_t               dec,
  input  wire logic [`CPU_DATA_W-1:0] write_data,
  output logic [`CPU_DATA_W-1:0]      ra_data,
  output logic [`CPU_DATA_W-1:0]      rb_data
);

  logic [`CPU_DATA_W-1:0]     regs [2**`CPU_REG_ADDR_W];
  logic [`CPU_REG_ADDR_W-1:0] rb_sel;

  // A store reads its source data through rd
  assign rb_sel = dec.is_store ? dec.rd : dec.rb;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**`CPU_REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (step.write_back && dec.writes_reg) begin
      regs[dec.rd] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (step.reg_read) begin
      ra_data <= regs[dec.ra];
      rb_data <= regs[rb_sel];
    end
  end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module alu import cpu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire ctrl_step_t             step,
  input  wire decoded_t               dec,
  input  wire logic [`CPU_DATA_W-1:0] ra_data,
  input  wire logic [`CPU_DATA_W-1:0] rb_data,
  output logic [`CPU_DATA_W-1:0]      result
);

  logic [`CPU_DATA_W-1:0] op_b;
  logic [`CPU_DATA_W-1:0] res_next;
  alu_func_e              func;

  assign op_b = dec.use_imm ? dec.imm : rb_data;

  // Address generation for memory access is always an add
  assign func = (dec.is_load || dec.is_store) ? ADD : dec.func;

  always_comb begin
    case (func)
      ADD:     res_next = ra_data + op_b;
      SUB:     res_next = ra_data - op_b;
      AND:     res_next = ra_data & op_b;
      OR:      res_next = ra_data | op_b;
      XOR:     res_next = ra_data ^ op_b;
      default: res_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (step.execute) begin
      result <= res_next;
    end
  end

endmodule

`default_nettype wire

// File: source/mem_interface.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module mem_interface import cpu_pkg::*; (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire ctrl_step_t                step,
  input  wire logic                      boot_phase,
  input  wire logic                      boot_fetch,
  input  wire logic [`CPU_IM_ADDR_W-1:0] pc,
  input  wire decoded_t                  dec,
  input  wire logic [`CPU_DATA_W-1:0]    alu_result,
  input  wire logic [`CPU_DATA_W-1:0]    store_data,
  input  wire rom_word_t                 rom_data,
  input  wire logic [`CPU_DATA_W-1:0]    dm_rdata,
  output im_req_t                        rom_req,
  output im_req_t                        im_req,
  output dm_req_t                        dm_req,
  output logic [`CPU_DATA_W-1:0]         write_data,
  output logic                           boot_last
);

  logic boot_write;
  logic fetch_q;

  assign boot_write = boot_phase && !boot_fetch;
  assign boot_last  = rom_data.last;

  // FETCH follows the final boot write and every write-back
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= 1'b0;
    end else begin
      fetch_q <= (boot_write && rom_data.last) || step.write_back;
    end
  end

  // ******************************
  // Memory requests
  // ******************************
  assign rom_req.en    = boot_phase && boot_fetch;
  assign rom_req.write = 1'b0;
  assign rom_req.addr  = `CPU_DM_ADDR_W'(pc);
  assign rom_req.wdata = '0;

  assign im_req.en    = boot_write || fetch_q;
  assign im_req.write = boot_write;
  assign im_req.addr  = `CPU_DM_ADDR_W'(pc);
  assign im_req.wdata = boot_write ? rom_data.instr : '0;

  // MEMORY is only entered for loads and stores
  assign dm_req.en    = step.mem_access;
  assign dm_req.write = step.mem_access && dec.is_store;
  assign dm_req.addr  = alu_result[`CPU_DM_ADDR_W-1:0];
  assign dm_req.wdata = store_data;

  assign write_data = dec.is_load ? dm_rdata : alu_result;

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
  input  wire logic                   clk,
  input  wire logic                   rst,
  output im_req_t                     rom_req,
  input  wire rom_word_t              rom_data,
  output im_req_t                     im_req,
  input  wire logic [`CPU_DATA_W-1:0] im_rdata,
  output dm_req_t                     dm_req,
  input  wire logic [`CPU_DATA_W-1:0] dm_rdata,
  output logic                        halted,
  output logic [`CPU_CYCLE_W-1:0]     cycle_cnt,
  output logic [`CPU_ICNT_W-1:0]      instr_cnt
);

  ctrl_step_t                  step;
  decoded_t                    dec;
  logic                        boot_phase;
  logic                        boot_last;
  logic                        boot_fetch;
  logic                        pc_inc;
  logic                        pc_clear;
  logic                        retire;
  logic                        count_cycles;
  logic [`CPU_IM_ADDR_W-1:0]   pc;
  logic [`CPU_DATA_W-1:0]      ra_data;
  logic [`CPU_DATA_W-1:0]      rb_data;
  logic [`CPU_DATA_W-1:0]      alu_result;
  logic [`CPU_DATA_W-1:0]      write_data;

  // The ROM read cycle of a boot word is the one that does not move the PC
  assign boot_fetch   = boot_phase && !pc_inc && !pc_clear;
  assign count_cycles = !boot_phase && !halted;

  cpu_controller cpu_controller_inst (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec),
    .boot_last  (boot_last),
    .step       (step),
    .boot_phase (boot_phase),
    .pc_inc     (pc_inc),
    .pc_clear   (pc_clear),
    .retire     (retire),
    .halted     (halted)
  );

  pc_counter pc_counter_inst (
    .clk          (clk),
    .rst          (rst),
    .pc_inc       (pc_inc),
    .pc_clear     (pc_clear),
    .count_cycles (count_cycles),
    .retire       (retire),
    .pc           (pc),
    .cycle_cnt    (cycle_cnt),
    .instr_cnt    (instr_cnt)
  );

  instr_decoder instr_decoder_inst (
    .clk      (clk),
    .rst      (rst),
    .step     (step),
    .im_rdata (im_rdata),
    .dec      (dec)
  );

  regfile regfile_inst (
    .clk        (clk),
    .rst        (rst),
    .step       (step),
    .dec        (dec),
    .write_data (write_data),
    .ra_data    (ra_data),
    .rb_data    (rb_data)
  );

  alu alu_inst (
    .clk     (clk),
    .rst     (rst),
    .step    (step),
    .dec     (dec),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .result  (alu_result)
  );

  mem_interface mem_interface_inst (
    .clk        (clk),
    .rst        (rst),
    .step       (step),
    .boot_phase (boot_phase),
    .boot_fetch (boot_fetch),
    .pc         (pc),
    .dec        (dec),
    .alu_result (alu_result),
    .store_data (rb_data),
    .rom_data   (rom_data),
    .dm_rdata   (dm_rdata),
    .rom_req    (rom_req),
    .im_req     (im_req),
    .dm_req     (dm_req),
    .write_data (write_data),
    .boot_last  (boot_last)
  );

endmodule

`default_nettype wire

// File: dv/cpu_top_props.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_top_props import cpu_pkg::*; (
  input wire logic                    clk,
  input wire logic                    rst,
  input wire im_req_t                 rom_req,
  input wire im_req_t                 im_req,
  input wire dm_req_t                 dm_req,
  input wire logic                    halted,
  input wire logic                    boot_phase,
  input wire logic [`CPU_CYCLE_W-1:0] cycle_cnt,
  input wire logic [`CPU_ICNT_W-1:0]  instr_cnt
);

  // Number of failed assertions
  int unsigned violations = 0;

  // The ROM read of the first boot word is already under way during reset
  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !im_req.en && !dm_req.en && !halted && cycle_cnt == '0 && instr_cnt == '0)
    else begin
      violations++;
      $error("Memory enable, halted or a counter was active right after reset");
    end

  halted_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else begin
      violations++;
      $error("Halted dropped after it had been raised");
    end

  halted_quiet: assert property (@(posedge clk) disable iff (rst)
    halted |-> !rom_req.en && !im_req.en && !dm_req.en)
    else begin
      violations++;
      $error("A memory enable was raised while halted");
    end

  rom_read_only: assert property (@(posedge clk) disable iff (rst) !rom_req.write)
    else begin
      violations++;
      $error("The boot ROM saw a write strobe");
    end

  im_write_boot_only: assert property (@(posedge clk) disable iff (rst)
    (im_req.en && im_req.write) |-> boot_phase)
    else begin
      violations++;
      $error("Instruction memory was written outside the boot phase");
    end

endmodule

bind cpu_top cpu_top_props cpu_top_props_inst (
  .clk        (clk),
  .rst        (rst),
  .rom_req    (rom_req),
  .im_req     (im_req),
  .dm_req     (dm_req),
  .halted     (halted),
  .boot_phase (boot_phase),
  .cycle_cnt  (cycle_cnt),
  .instr_cnt  (instr_cnt)
);

`default_nettype wire

// File: dv/cpu_top_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "cpu_settings.svh"

module cpu_top_tb import cpu_pkg::*; ();

  logic                      clk;
  logic                      rst;
  im_req_t                   rom_req;
  rom_word_t                 rom_data;
  im_req_t                   im_req;
  logic [`CPU_DATA_W-1:0]    im_rdata;
  dm_req_t                   dm_req;
  logic [`CPU_DATA_W-1:0]    dm_rdata;
  logic                      halted;
  logic [`CPU_CYCLE_W-1:0]   cycle_cnt;
  logic [`CPU_ICNT_W-1:0]    instr_cnt;

  rom_word_t                 rom_mem [2**`CPU_IM_ADDR_W];
  logic [`CPU_DATA_W-1:0]    im_mem [2**`CPU_IM_ADDR_W];
  logic [`CPU_DATA_W-1:0]    dm_mem [2**`CPU_DM_ADDR_W];
  logic [`CPU_DATA_W-1:0]    ref_dm [2**`CPU_DM_ADDR_W];

  // Generated program, one entry per instruction
  logic [5:0]                p_op [64];
  logic [4:0]                p_rd [64];
  logic [4:0]                p_ra [64];
  logic [4:0]                p_rb [64];
  logic [4:0]                p_func [64];
  logic [14:0]               p_imm [64];
  int                        prog_len;
  int                        exp_cycles;
  logic                      prog_ready;

  logic [`CPU_DM_ADDR_W-1:0] exp_addr [$];
  logic [`CPU_DATA_W-1:0]    exp_data [$];
  logic [`CPU_IM_ADDR_W-1:0] rom_addr_q;
  int                        boot_words;
  int                        errors;
  integer                    seed;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .rst       (rst),
    .rom_req   (rom_req),
    .rom_data  (rom_data),
    .im_req    (im_req),
    .im_rdata  (im_rdata),
    .dm_req    (dm_req),
    .dm_rdata  (dm_rdata),
    .halted    (halted),
    .cycle_cnt (cycle_cnt),
    .instr_cnt (instr_cnt)
  );

  always #4 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    errors++;
    $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
  endtask

  function automatic logic [31:0] sign_ext15(input logic [14:0] imm);
    return {{17{imm[14]}}, imm};
  endfunction

  function automatic logic [31:0] dm_fill(input int addr);
    return 32'hdada_0000 ^ 32'(addr * 7);
  endfunction

  function automatic logic [31:0] alu_ref(input logic [4:0] func, input logic [31:0] a,
                                          input logic [31:0] b);
    case (func)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] encode_word(input int i);
    if (p_op[i] == OP_ALU) begin
      return {p_op[i], p_rd[i], p_ra[i], p_rb[i], 6'b0, p_func[i]};
    end
    return {p_op[i], p_rd[i], p_ra[i], 1'b0, p_imm[i]};
  endfunction

  task automatic add_instr(input logic [5:0] op, input logic [4:0] rd, input logic [4:0] ra,
                           input logic [4:0] rb, input logic [4:0] func,
                           input logic [14:0] imm);
    p_op[prog_len]   = op;
    p_rd[prog_len]   = rd;
    p_ra[prog_len]   = ra;
    p_rb[prog_len]   = rb;
    p_func[prog_len] = func;
    p_imm[prog_len]  = imm;
    if (op == OP_LWI || op == OP_SWI) begin
      exp_cycles += 5;
    end else if (op == OP_HALT) begin
      exp_cycles += 3;
    end else begin
      exp_cycles += 4;
    end
    prog_len++;
  endtask

  // ******************************
  // Program and reference model
  // ******************************
  task automatic build_program();
    logic [31:0] rnd;
    logic [14:0] imm;
    logic [11:0] offs [6];
    for (int r = 1; r <= 8; r++) begin
      rnd = $random(seed);
      imm = rnd[14:0];
      // A small r1 lets r2 (ORI) and r3 (ADDI) show the extension in their upper bits
      if (r == 1) begin
        imm[14] = 1'b0;
      end else if (r <= 3) begin
        imm[14] = 1'b1;
      end
      add_instr((r % 2 == 1) ? OP_ADDI : OP_ORI, 5'(r), 5'(r - 1), 5'd0, 5'd0, imm);
    end
    // The last five operations leave one result per function in r9 to r13
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      add_instr(OP_ALU, 5'(9 + i % 7), 5'(1 + rnd[11:8] % 15),
                5'(1 + rnd[15:12] % 15), 5'(i % 5), 15'd0);
    end
    // Stores read r8 with both extensions and r9 to r13
    for (int k = 0; k < 6; k++) begin
      rnd = $random(seed);
      offs[k] = {rnd[11:3], 3'(k)};
      add_instr(OP_SWI, 5'(8 + k), 5'd0, 5'd0, 5'd0, {3'b0, offs[k]});
    end
    for (int k = 0; k < 6; k++) begin
      add_instr(OP_LWI, 5'(16 + k), 5'd0, 5'd0, 5'd0, {3'b0, offs[k]});
    end
    for (int k = 0; k < 6; k++) begin
      add_instr(OP_SWI, 5'(16 + k), 5'd0, 5'd0, 5'd0, {3'b0, offs[k] ^ 12'h800});
    end
    add_instr(OP_HALT, 5'd0, 5'd0, 5'd0, 5'd0, 15'd0);
  endtask

  task automatic load_memories();
    for (int a = 0; a < 2**`CPU_IM_ADDR_W; a++) begin
      rom_mem[a] = {1'b0, 32'hfc00_0000 | 32'(a)};
      im_mem[a]  = 32'h5a5a_0000 ^ 32'(a * 3);
    end
    for (int a = 0; a < 2**`CPU_DM_ADDR_W; a++) begin
      dm_mem[a] = dm_fill(a);
    end
    for (int i = 0; i < prog_len; i++) begin
      rom_mem[i] = {(i == prog_len - 1), encode_word(i)};
    end
  endtask

  task automatic run_reference();
    logic [31:0] regs [32];
    logic [11:0] addr;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int a = 0; a < 2**`CPU_DM_ADDR_W; a++) begin
      ref_dm[a] = dm_fill(a);
    end
    for (int i = 0; i < prog_len; i++) begin
      addr = 12'(regs[p_ra[i]] + sign_ext15(p_imm[i]));
      case (p_op[i])
        OP_ALU:  regs[p_rd[i]] = alu_ref(p_func[i], regs[p_ra[i]], regs[p_rb[i]]);
        OP_ADDI: regs[p_rd[i]] = regs[p_ra[i]] + sign_ext15(p_imm[i]);
        OP_ORI:  regs[p_rd[i]] = regs[p_ra[i]] | {17'b0, p_imm[i]};
        OP_LWI:  regs[p_rd[i]] = ref_dm[addr];
        OP_SWI: begin
          ref_dm[addr] = regs[p_rd[i]];
          exp_addr.push_back(addr);
          exp_data.push_back(regs[p_rd[i]]);
        end
        default: begin
        end
      endcase
    end
  endtask

  // Checks first, then the memory models answer the request of this cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (im_req.en && im_req.write) begin
        assert (im_req.addr == `CPU_DM_ADDR_W'(boot_words))
          else report_mismatch("boot_addr", boot_words, im_req.addr);
        assert (im_req.addr == `CPU_DM_ADDR_W'(rom_addr_q))
          else report_mismatch("boot_addr_vs_rom", rom_addr_q, im_req.addr);
        assert (im_req.wdata == rom_mem[rom_addr_q].instr)
          else report_mismatch("boot_data", rom_mem[rom_addr_q].instr, im_req.wdata);
        boot_words++;
      end
      if (dm_req.en && dm_req.write) begin
        assert (exp_addr.size() != 0) else begin
          errors++;
          $display("Data memory write at %0h with no store left in the reference", dm_req.addr);
        end
        if (exp_addr.size() != 0) begin
          assert (dm_req.addr == exp_addr[0])
            else report_mismatch("store_addr", exp_addr[0], dm_req.addr);
          assert (dm_req.wdata == exp_data[0])
            else report_mismatch("store_data", exp_data[0], dm_req.wdata);
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
        end
      end
    end
    if (rom_req.en) begin
      rom_addr_q = rom_req.addr[`CPU_IM_ADDR_W-1:0];
      rom_data <= rom_mem[rom_addr_q];
    end
    if (im_req.en && im_req.write) begin
      im_mem[im_req.addr[`CPU_IM_ADDR_W-1:0]] = im_req.wdata;
    end else if (im_req.en) begin
      im_rdata <= im_mem[im_req.addr[`CPU_IM_ADDR_W-1:0]];
    end
    if (dm_req.en && dm_req.write) begin
      dm_mem[dm_req.addr] = dm_req.wdata;
    end else if (dm_req.en) begin
      dm_rdata <= dm_mem[dm_req.addr];
    end
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    rom_data   = '0;
    im_rdata   = '0;
    dm_rdata   = '0;
    rom_addr_q = '0;
    boot_words = 0;
    errors     = 0;
    prog_len   = 0;
    exp_cycles = 0;
    prog_ready = 1'b0;
    seed       = 32'habbd_11f4;
    build_program();
    load_memories();
    run_reference();
    prog_ready = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!halted) begin
      @(negedge clk);
    end
    // The counters settle one cycle after halted rises
    repeat (2) @(negedge clk);
    assert (instr_cnt == `CPU_ICNT_W'(prog_len))
      else report_mismatch("instr_cnt", prog_len, instr_cnt);
    assert (cycle_cnt == `CPU_CYCLE_W'(exp_cycles))
      else report_mismatch("cycle_cnt", exp_cycles, cycle_cnt);
    assert (boot_words == prog_len) else report_mismatch("boot_words", prog_len, boot_words);
    assert (exp_addr.size() == 0) else begin
      errors++;
      $display("%0d expected stores never reached data memory", exp_addr.size());
    end
    $display("Errors: %0d from checks, %0d from assertions", errors,
             cpu_top_inst.cpu_top_props_inst.violations);
    if (errors == 0 && cpu_top_inst.cpu_top_props_inst.violations == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Boot takes 2 cycles per word and no instruction takes more than 5
  initial begin
    wait (prog_ready);
    repeat (2 * prog_len + 5 * prog_len + 50) @(posedge clk);
    $display("Timeout: the DUT did not halt within %0d cycles", 7 * prog_len + 50);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_top.f
+incdir+source
source/cpu_pkg.sv
source/cpu_controller.sv
source/pc_counter.sv
source/instr_decoder.sv
source/regfile.sv
source/alu.sv
source/mem_interface.sv
source/cpu_top.sv
dv/cpu_top_props.sv
dv/cpu_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_top_tb \
  -f cpu_top.f --Mdir obj_dir -o cpu_top_sim \
  && ./obj_dir/cpu_top_sim +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -x "Testbench passed" > /dev/null \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
